//--- sources.f
verilog/cache_pkg.sv
verilog/write_align.sv
verilog/data_store.sv
verilog/tag_store.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/bus_mem_model.sv
tb/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module cache_tb \
   -f sources.f -o cache_sim \
   && ./obj_dir/cache_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- tb/cache_tb.sv
module cache_tb;

   localparam int TIMEOUT = 200;

   logic             clk;
   logic             rst_n;
   logic             enable;
   logic             rw;
   cache_pkg::addr_t addr;
   cache_pkg::size_t size;
   cache_pkg::line_t data_write;
   cache_pkg::line_t data_read;
   logic             ready;
   logic             bus_en;
   logic             bus_wr;
   cache_pkg::addr_t bus_addr;
   cache_pkg::line_t bus_write;
   logic             bus_ready;
   cache_pkg::line_t bus_read;
   int               rd_count;
   int               wr_count;

   // architectural memory as the processor sees it
   logic [7:0]       shadow [1 << cache_pkg::ADDR_W];
   // expected cache directory
   logic             valid_m [cache_pkg::NUM_LINES];
   logic             dirty_m [cache_pkg::NUM_LINES];
   cache_pkg::tag_t  tag_m [cache_pkg::NUM_LINES];

   // expectations for the request in flight
   cache_pkg::line_t exp_line;
   cache_pkg::addr_t exp_fill_addr;
   cache_pkg::addr_t exp_wb_addr;
   cache_pkg::line_t exp_wb_line;
   int               exp_reads;
   int               exp_writes;
   int               rd_base;
   int               wr_base;
   logic             in_flight;
   int               errors;
   int               errors_at_start;
   int               test_num;
   int               tests_failed;

   cache_top cache_top_i
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .enable     (enable),
      .rw         (rw),
      .addr       (addr),
      .size       (size),
      .data_write (data_write),
      .data_read  (data_read),
      .ready      (ready),
      .bus_en     (bus_en),
      .bus_wr     (bus_wr),
      .bus_addr   (bus_addr),
      .bus_write  (bus_write),
      .bus_ready  (bus_ready),
      .bus_read   (bus_read)
   );

   bus_mem_model bus_mem_i
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus_en    (bus_en),
      .bus_wr    (bus_wr),
      .bus_addr  (bus_addr),
      .bus_write (bus_write),
      .bus_ready (bus_ready),
      .bus_read  (bus_read),
      .rd_count  (rd_count),
      .wr_count  (wr_count)
   );

   always #2 clk = ~clk;

   a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> data_read == exp_line)
      else
      begin
         errors++;
         $display("error at %0t: data_read = %h, expected %h", $time, data_read, exp_line);
      end

   a_fill_addr: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en && !bus_wr |-> bus_addr == exp_fill_addr)
      else
      begin
         errors++;
         $display("error at %0t: bus_addr = %h, expected %h", $time, bus_addr, exp_fill_addr);
      end

   a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en && bus_wr |-> bus_addr == exp_wb_addr)
      else
      begin
         errors++;
         $display("error at %0t: bus_addr = %h, expected %h", $time, bus_addr, exp_wb_addr);
      end

   a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en && bus_wr |-> bus_write == exp_wb_line)
      else
      begin
         errors++;
         $display("error at %0t: bus_write = %h, expected %h", $time, bus_write, exp_wb_line);
      end

   // write-back must be finished before the refill starts
   a_wb_first: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en && !bus_wr |-> (wr_count - wr_base) == exp_writes)
      else
      begin
         errors++;
         $display("refill started before the expected write-back at %0t", $time);
      end

   a_counts: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> (rd_count - rd_base) == exp_reads && (wr_count - wr_base) == exp_writes)
      else
      begin
         errors++;
         $display("wrong number of bus transfers at %0t: %0d reads, %0d writes",
                  $time, rd_count - rd_base, wr_count - wr_base);
      end

   a_no_bus_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en |-> exp_reads != 0)
      else
      begin
         errors++;
         $display("bus used on a cache hit at %0t", $time);
      end

   a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en && !bus_ready |=>
         bus_en && $stable(bus_addr) && $stable(bus_wr) && $stable(bus_write))
      else
      begin
         errors++;
         $display("bus request changed while waiting for bus_ready at %0t", $time);
      end

   a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      !in_flight |-> !ready && !bus_en)
      else
      begin
         errors++;
         $display("ready or bus_en high with no request pending at %0t", $time);
      end

   function automatic cache_pkg::line_t random_line();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   function automatic cache_pkg::line_t line_of(input cache_pkg::addr_t a);
      cache_pkg::line_t l;
      int               base;
      base = int'({a[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W], 4'h0});
      for (int b = 0; b < 16; b++)
         l[b*8 +: 8] = shadow[base + b];
      return l;
   endfunction

   // size 1, 2, 4 or 8 writes that many bytes from the offset
   // bytes past 15 are dropped
   // any other code writes the whole line
   function automatic void write_shadow(input cache_pkg::addr_t a, input cache_pkg::size_t sz,
                                        input cache_pkg::line_t d);
      int base;
      int off;
      int n;
      base = int'({a[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W], 4'h0});
      off  = int'(a[cache_pkg::OFFSET_W-1:0]);
      case (sz)
         4'd1: n = 1;
         4'd2: n = 2;
         4'd4: n = 4;
         4'd8: n = 8;
         default: n = 0;
      endcase
      if (n == 0)
      begin
         for (int i = 0; i < 16; i++)
            shadow[base + i] = d[i*8 +: 8];
      end
      else
      begin
         for (int i = 0; i < n; i++)
         begin
            if (off + i < 16)
               shadow[base + off + i] = d[i*8 +: 8];
         end
      end
   endfunction

   task automatic fill_memory();
      cache_pkg::line_t v;
      for (int i = 0; i < (1 << (cache_pkg::ADDR_W - cache_pkg::OFFSET_W)); i++)
      begin
         v = random_line();
         bus_mem_i.lines[i] = v;
         for (int b = 0; b < 16; b++)
            shadow[i*16 + b] = v[b*8 +: 8];
      end
      for (int k = 0; k < cache_pkg::NUM_LINES; k++)
      begin
         valid_m[k] = 1'b0;
         dirty_m[k] = 1'b0;
         tag_m[k]   = '0;
      end
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready && n < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!ready)
      begin
         $display("timeout: no ready within %0d cycles at %0t", TIMEOUT, $time);
         $display("Test FAILED");
         $finish;
      end
   endtask

   task automatic request(input logic wr, input cache_pkg::addr_t a,
                          input cache_pkg::size_t sz, input cache_pkg::line_t d);
      cache_pkg::index_t idx;
      cache_pkg::tag_t   tg;
      idx = a[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
      tg  = a[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
      @(posedge clk);
      #1;
      exp_reads  = 0;
      exp_writes = 0;
      if (!(valid_m[idx] && tag_m[idx] == tg))
      begin
         exp_reads = 1;
         // a dirty victim goes back to memory first
         if (valid_m[idx] && dirty_m[idx])
         begin
            exp_writes  = 1;
            exp_wb_addr = {tag_m[idx], idx, 4'h0};
            exp_wb_line = line_of(exp_wb_addr);
         end
         valid_m[idx] = 1'b1;
         tag_m[idx]   = tg;
         dirty_m[idx] = 1'b0;
      end
      if (wr)
      begin
         write_shadow(a, sz, d);
         dirty_m[idx] = 1'b1;
      end
      exp_fill_addr = {a[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W], 4'h0};
      exp_line      = line_of(a);
      rd_base       = rd_count;
      wr_base       = wr_count;
      in_flight     = 1'b1;
      rw            = wr;
      addr          = a;
      size          = sz;
      data_write    = d;
      enable        = 1'b1;
      @(posedge clk);
      #1;
      enable = 1'b0;
      wait_ready();
      @(posedge clk);
      #1;
      in_flight = 1'b0;
   endtask

   task automatic start_test();
      errors_at_start = errors;
   endtask

   task automatic end_test(input string name);
      int n;
      n = errors - errors_at_start;
      test_num++;
      if (n == 0)
         $display("test %0d %s: passed", test_num, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", test_num, name, n);
      end
   endtask

   task automatic run_write_hits();
      int               offs [6];
      cache_pkg::size_t sizes [6];
      offs  = '{3, 15, 13, 5, 9, 7};
      sizes = '{4'd1, 4'd2, 4'd4, 4'd8, 4'd0, 4'd5};
      start_test();
      for (int i = 0; i < 6; i++)
         request(1'b1, cache_pkg::addr_t'(16'h1230 + offs[i]), sizes[i], random_line());
      request(1'b0, 16'h1234, 4'd0, '0);
      end_test("write hits of each size");
   endtask

   task automatic run_random();
      cache_pkg::size_t sizes [6];
      cache_pkg::addr_t a;
      int               k;
      sizes = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd8, 4'd3};
      start_test();
      // few tags and indexes so that lines conflict often
      for (int i = 0; i < 60; i++)
      begin
         k = $urandom % 6;
         a = {cache_pkg::tag_t'($urandom % 4), cache_pkg::index_t'($urandom % 4),
              cache_pkg::offset_t'($urandom)};
         request(1'($urandom % 2), a, sizes[k], random_line());
      end
      end_test("random mix with bus delays");
   endtask

   initial
   begin
      clk             = 1'b0;
      rst_n           = 1'b0;
      enable          = 1'b0;
      rw              = 1'b0;
      addr            = '0;
      size            = '0;
      data_write      = '0;
      in_flight       = 1'b0;
      exp_line        = '0;
      exp_fill_addr   = '0;
      exp_wb_addr     = '0;
      exp_wb_line     = '0;
      exp_reads       = 0;
      exp_writes      = 0;
      rd_base         = 0;
      wr_base         = 0;
      errors          = 0;
      errors_at_start = 0;
      test_num        = 0;
      tests_failed    = 0;
      void'($urandom(58));
      fill_memory();
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      start_test();
      repeat (3) @(posedge clk);
      request(1'b0, 16'h1234, 4'd0, '0);
      end_test("reset and first read miss");

      run_write_hits();

      start_test();
      request(1'b0, 16'h0a60, 4'd0, '0);
      request(1'b1, 16'h2a67, 4'd4, random_line());
      end_test("write miss to clean line");

      start_test();
      request(1'b0, 16'h9234, 4'd0, '0);
      request(1'b0, 16'h1234, 4'd0, '0);
      end_test("dirty victim write-back");

      run_random();

      $display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- tb/bus_mem_model.sv
module bus_mem_model
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             bus_en,
   input  logic             bus_wr,
   input  cache_pkg::addr_t bus_addr,
   input  cache_pkg::line_t bus_write,
   output logic             bus_ready,
   output cache_pkg::line_t bus_read,
   output int               rd_count,
   output int               wr_count
);

   // one entry per line of the 16-bit address space
   cache_pkg::line_t lines [1 << (cache_pkg::ADDR_W - cache_pkg::OFFSET_W)];

   // copy of the request as seen in the current cycle
   logic             held_en;
   logic             held_wr;
   cache_pkg::addr_t held_addr;
   cache_pkg::line_t held_write;
   int               waited;
   int               delay;

   initial
   begin
      bus_ready  = 1'b0;
      bus_read   = '0;
      rd_count   = 0;
      wr_count   = 0;
      held_en    = 1'b0;
      held_wr    = 1'b0;
      held_addr  = '0;
      held_write = '0;
      waited     = 0;
      delay      = 2;
      forever
      begin
         @(posedge clk);
         if (!rst_n)
         begin
            waited = 0;
         end
         else if (held_en && bus_ready)
         begin
            // transfer completes on this edge
            if (held_wr)
            begin
               lines[held_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W]] = held_write;
               wr_count++;
            end
            else
               rd_count++;
            waited = 0;
            delay  = $urandom % 6;
         end
         else if (held_en)
         begin
            waited++;
         end
         #1;
         held_en    = bus_en;
         held_wr    = bus_wr;
         held_addr  = bus_addr;
         held_write = bus_write;
         bus_ready  = held_en && (waited >= delay);
         bus_read   = lines[held_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W]];
      end
   end

endmodule

//--- verilog/cache_top.sv
module cache_top
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 enable,
   input  logic                 rw,
   input  cache_pkg::addr_t     addr,
   input  cache_pkg::size_t     size,
   input  cache_pkg::line_t     data_write,
   output cache_pkg::line_t     data_read,
   output logic                 ready,
   output logic                 bus_en,
   output logic                 bus_wr,
   output cache_pkg::addr_t     bus_addr,
   output cache_pkg::line_t     bus_write,
   input  logic                 bus_ready,
   input  cache_pkg::line_t     bus_read
);

   cache_pkg::index_t     req_index;
   cache_pkg::tag_t       req_tag;
   cache_pkg::offset_t    req_offset;
   cache_pkg::size_t      req_size;
   cache_pkg::line_t      req_data;
   logic                  tag_fill;
   logic                  tag_mark_dirty;
   logic                  fill_we;
   logic                  word_we;
   logic                  hit;
   logic                  victim_dirty;
   cache_pkg::tag_t       victim_tag;
   cache_pkg::byte_mask_t wr_mask;
   cache_pkg::line_t      wr_line;
   cache_pkg::line_t      rd_line;

   // the line at req_index feeds both the processor and the write-back
   assign data_read = rd_line;
   assign bus_write = rd_line;

   cache_ctrl cache_ctrl_i
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .enable         (enable),
      .rw             (rw),
      .addr           (addr),
      .size           (size),
      .data_write     (data_write),
      .hit            (hit),
      .victim_dirty   (victim_dirty),
      .victim_tag     (victim_tag),
      .bus_ready      (bus_ready),
      .req_index      (req_index),
      .req_tag        (req_tag),
      .req_offset     (req_offset),
      .req_size       (req_size),
      .req_data       (req_data),
      .tag_fill       (tag_fill),
      .tag_mark_dirty (tag_mark_dirty),
      .fill_we        (fill_we),
      .word_we        (word_we),
      .ready          (ready),
      .bus_en         (bus_en),
      .bus_wr         (bus_wr),
      .bus_addr       (bus_addr)
   );

   tag_store tag_store_i
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .req_index      (req_index),
      .req_tag        (req_tag),
      .tag_fill       (tag_fill),
      .tag_mark_dirty (tag_mark_dirty),
      .hit            (hit),
      .victim_dirty   (victim_dirty),
      .victim_tag     (victim_tag)
   );

   data_store data_store_i
   (
      .clk       (clk),
      .req_index (req_index),
      .fill_we   (fill_we),
      .word_we   (word_we),
      .fill_line (bus_read),
      .wr_line   (wr_line),
      .wr_mask   (wr_mask),
      .rd_line   (rd_line)
   );

   write_align write_align_i
   (
      .req_offset (req_offset),
      .req_size   (req_size),
      .req_data   (req_data),
      .wr_mask    (wr_mask),
      .wr_line    (wr_line)
   );

endmodule

//--- verilog/cache_ctrl.sv
module cache_ctrl
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               enable,
   input  logic               rw,
   input  cache_pkg::addr_t   addr,
   input  cache_pkg::size_t   size,
   input  cache_pkg::line_t   data_write,
   input  logic               hit,
   input  logic               victim_dirty,
   input  cache_pkg::tag_t    victim_tag,
   input  logic               bus_ready,
   output cache_pkg::index_t  req_index,
   output cache_pkg::tag_t    req_tag,
   output cache_pkg::offset_t req_offset,
   output cache_pkg::size_t   req_size,
   output cache_pkg::line_t   req_data,
   output logic               tag_fill,
   output logic               tag_mark_dirty,
   output logic               fill_we,
   output logic               word_we,
   output logic               ready,
   output logic               bus_en,
   output logic               bus_wr,
   output cache_pkg::addr_t   bus_addr
);

   typedef enum logic [2:0]
   {
      st_idle,
      st_lookup,
      st_write_back,
      st_refill,
      st_access
   } state_t;

   state_t state;
   state_t next_state;
   logic   req_rw;
   logic   sample;

   // no new request while ready is still being pulsed
   assign sample = (state == st_idle) && enable && !ready;

   // request latch
   always_ff @(posedge clk)
   begin
      if (sample)
      begin
         req_tag    <= addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
         req_index  <= addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
         req_offset <= addr[cache_pkg::OFFSET_W-1:0];
         req_size   <= size;
         req_data   <= data_write;
         req_rw     <= rw;
      end
   end

   always_comb
   begin
      next_state = state;
      case (state)
         st_idle:
         begin
            if (sample)
               next_state = st_lookup;
         end
         st_lookup:
         begin
            if (hit)
               next_state = st_access;
            else if (victim_dirty)
               next_state = st_write_back;
            else
               next_state = st_refill;
         end
         st_write_back:
         begin
            if (bus_ready)
               next_state = st_refill;
         end
         st_refill:
         begin
            if (bus_ready)
               next_state = st_access;
         end
         st_access:
            next_state = st_idle;
         default:
            next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= st_idle;
         ready <= 1'b0;
      end
      else
      begin
         state <= next_state;
         // ready lands one cycle after access, so the write is visible
         ready <= (state == st_access);
      end
   end

   // refill writes line and tag on the completing bus cycle
   assign fill_we        = (state == st_refill) && bus_ready;
   assign tag_fill       = fill_we;
   assign word_we        = (state == st_access) && req_rw;
   assign tag_mark_dirty = word_we;

   assign bus_en = (state == st_write_back) || (state == st_refill);
   assign bus_wr = (state == st_write_back);

   // write-back goes to the victim's line, refill to the request's line
   assign bus_addr = bus_wr ?
                     {victim_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}} :
                     {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};

   a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en && !bus_ready |=> $stable(bus_addr) && $stable(bus_wr))
      else $error("bus request changed while waiting for bus_ready");

   a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      ready |=> !ready)
      else $error("ready held high for more than one cycle");

endmodule

//--- verilog/tag_store.sv
module tag_store
(
   input  logic              clk,
   input  logic              rst_n,
   input  cache_pkg::index_t req_index,
   input  cache_pkg::tag_t   req_tag,
   input  logic              tag_fill,
   input  logic              tag_mark_dirty,
   output logic              hit,
   output logic              victim_dirty,
   output cache_pkg::tag_t   victim_tag
);

   cache_pkg::tag_t                tags [cache_pkg::NUM_LINES];
   logic [cache_pkg::NUM_LINES-1:0] valid;
   logic [cache_pkg::NUM_LINES-1:0] dirty;
   logic                           tag_match;

   // new tag on every refill
   always_ff @(posedge clk)
   begin
      if (tag_fill)
         tags[req_index] <= req_tag;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid <= '0;
         dirty <= '0;
      end
      else if (tag_fill)
      begin
         // a fresh line from memory is clean
         valid[req_index] <= 1'b1;
         dirty[req_index] <= 1'b0;
      end
      else if (tag_mark_dirty)
      begin
         dirty[req_index] <= 1'b1;
      end
   end

   assign victim_tag   = tags[req_index];
   assign tag_match    = (victim_tag == req_tag);
   assign hit          = valid[req_index] && tag_match;
   // only a different, modified line needs a write-back
   assign victim_dirty = valid[req_index] && dirty[req_index] && !tag_match;

   a_one_update: assert property (@(posedge clk) disable iff (!rst_n)
      !(tag_fill && tag_mark_dirty))
      else $error("tag fill and dirty mark in the same cycle");

endmodule

//--- verilog/data_store.sv
module data_store
(
   input  logic                  clk,
   input  cache_pkg::index_t     req_index,
   input  logic                  fill_we,
   input  logic                  word_we,
   input  cache_pkg::line_t      fill_line,
   input  cache_pkg::line_t      wr_line,
   input  cache_pkg::byte_mask_t wr_mask,
   output cache_pkg::line_t      rd_line
);

   cache_pkg::line_t mem [cache_pkg::NUM_LINES];

   always_ff @(posedge clk)
   begin
      if (fill_we)
      begin
         mem[req_index] <= fill_line;
      end
      else if (word_we)
      begin
         // only the selected bytes change
         for (int b = 0; b < cache_pkg::LINE_BYTES; b++)
         begin
            if (wr_mask[b])
               mem[req_index][b*8 +: 8] <= wr_line[b*8 +: 8];
         end
      end
   end

   // combinational read at the latched index
   assign rd_line = mem[req_index];

   a_one_writer: assert property (@(posedge clk)
      !(fill_we && word_we))
      else $error("line fill and masked write in the same cycle");

endmodule

//--- verilog/write_align.sv
module write_align
(
   input  cache_pkg::offset_t    req_offset,
   input  cache_pkg::size_t      req_size,
   input  cache_pkg::line_t      req_data,
   output cache_pkg::byte_mask_t wr_mask,
   output cache_pkg::line_t      wr_line
);

   cache_pkg::byte_mask_t run;
   logic                  full;

   // run of byte enables for the size code
   always_comb
   begin
      full = 1'b0;
      case (req_size)
         cache_pkg::SIZE_B1: run = cache_pkg::RUN_B1;
         cache_pkg::SIZE_B2: run = cache_pkg::RUN_B2;
         cache_pkg::SIZE_B4: run = cache_pkg::RUN_B4;
         cache_pkg::SIZE_B8: run = cache_pkg::RUN_B8;
         default:
         begin
            // SIZE_FULL and unknown codes
            run  = cache_pkg::RUN_FULL;
            full = 1'b1;
         end
      endcase
   end

   // bytes shifted past byte 15 fall off the top
   always_comb
   begin
      if (full)
      begin
         wr_mask = run;
         wr_line = req_data;
      end
      else
      begin
         wr_mask = run << req_offset;
         wr_line = req_data << {req_offset, 3'b000};
      end
   end

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

   // address split into tag, index and offset
   localparam int ADDR_W     = 16;
   localparam int LINE_BYTES = 16;
   localparam int LINE_W     = LINE_BYTES * 8;
   localparam int OFFSET_W   = 4;
   localparam int INDEX_W    = 5;
   localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
   localparam int NUM_LINES  = 1 << INDEX_W;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [LINE_W-1:0]     line_t;
   typedef logic [LINE_BYTES-1:0] byte_mask_t;
   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [INDEX_W-1:0]    index_t;
   typedef logic [OFFSET_W-1:0]   offset_t;
   typedef logic [3:0]            size_t;

   // size codes on the processor port
   // any code not listed here behaves as a full line write
   localparam size_t SIZE_FULL = 4'd0;
   localparam size_t SIZE_B1   = 4'd1;
   localparam size_t SIZE_B2   = 4'd2;
   localparam size_t SIZE_B4   = 4'd4;
   localparam size_t SIZE_B8   = 4'd8;

   // enable runs before shifting by the offset
   localparam byte_mask_t RUN_B1   = 16'h0001;
   localparam byte_mask_t RUN_B2   = 16'h0003;
   localparam byte_mask_t RUN_B4   = 16'h000f;
   localparam byte_mask_t RUN_B8   = 16'h00ff;
   localparam byte_mask_t RUN_FULL = 16'hffff;

endpackage
